//--- verilog/video_pkg.sv
//**********************************************************
// video stream widths, channel count and sync delay depth
// pixel word types for the filter input and output side
//**********************************************************

package video_pkg;

    // colour depth on each side of the filter
    localparam int win  = 4;                // retro core colour bits
    localparam int wout = 5;                // widened colour bits

    // r, g and b run through identical channels
    localparam int num_chan = 3;

    // sync lags by this many strobes when filtering
    // matches the centre tap of the fir
    localparam int sync_stages = 3;

    typedef logic [win-1:0]  pix_in_t;      // one input colour
    typedef logic [wout-1:0] pix_out_t;     // one output colour

endpackage

//--- verilog/filter_pkg.sv
//**********************************************************
// fir tap count, coefficient table and accumulator sizing
// shift and gap figures for the shared multiply-accumulate
//**********************************************************

package filter_pkg;

    localparam int num_taps = 5;            // filter order
    localparam int coeff_w  = 5;            // tap weight bits

    // three guard bits over the product, sum of weights is 34
    localparam int acc_w = video_pkg::win + coeff_w + 3;

    // drop weight bits but keep the extra output bit
    localparam int out_shift = coeff_w - (video_pkg::wout - video_pkg::win);

    // one tap per cycle plus the strobe cycle itself
    localparam int min_strobe_gap = num_taps + 1;

    // index 0 pairs with the newest sample
    typedef logic [0:num_taps-1][coeff_w-1:0] coeff_vec_t;

    localparam coeff_vec_t coeff_tab = {
        5'd0,                               // newest
        5'd7,
        5'd20,                              // centre tap
        5'd7,
        5'd0                                // oldest
    };

endpackage

//--- verilog/video_sync_if.sv
//**********************************************************
// sync and blanking bundle between front end and output
//**********************************************************

`timescale 1ns/1ps

interface video_sync_if;

    logic hs;                               // horizontal sync
    logic vs;                               // vertical sync
    logic lhb;                              // horizontal blank, low active
    logic lvb;                              // vertical blank, low active

    // front end selects which sync goes out
    modport src (
        output hs,
        output vs,
        output lhb,
        output lvb
    );

    // output stage registers it with colour
    modport dst (
        input hs,
        input vs,
        input lhb,
        input lvb
    );

endinterface

//--- verilog/sample_front.sv
//**********************************************************
// sample front end with strobe-clocked sync delay line
// delayed or raw sync selection, colour fan-out
//**********************************************************

`timescale 1ns/1ps

module sample_front (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                spl_in,     // sample strobe
    input  logic                enable,     // filtering on
    input  video_pkg::pix_in_t  r_in,
    input  video_pkg::pix_in_t  g_in,
    input  video_pkg::pix_in_t  b_in,
    input  logic                hs_in,
    input  logic                vs_in,
    input  logic                lhb_in,
    input  logic                lvb_in,
    output video_pkg::pix_in_t  chan_in [video_pkg::num_chan],
    video_sync_if.src           sync
);

    import video_pkg::*;

    // entry 0 holds the sync of the current strobe
    // entries above it are the delay proper
    logic [sync_stages:0][3:0] sync_line;   // hs vs lhb lvb per entry
    logic [3:0]                sync_raw;
    logic [3:0]                sync_dly;

    assign sync_raw = {hs_in, vs_in, lhb_in, lvb_in};
    assign sync_dly = sync_line[sync_stages]; // lines up with centre tap

    // shifts only on strobes, idles in between
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_line <= '0;                // sync low out of reset
        end else if (spl_in) begin
            sync_line <= {sync_line[sync_stages-1:0], sync_raw};
        end
    end

    // bypass mode has no fir latency to match
    always_comb begin
        if (enable) begin
            {sync.hs, sync.vs, sync.lhb, sync.lvb} = sync_dly;
        end else begin
            {sync.hs, sync.vs, sync.lhb, sync.lvb} = sync_raw;
        end
    end

    // channel order r, g, b
    assign chan_in[0] = r_in;
    assign chan_in[1] = g_in;
    assign chan_in[2] = b_in;

endmodule

//--- verilog/channel_fir.sv
//**********************************************************
// single colour channel, five-tap fir on one shared mac
// clamp to output range, bypass widening when disabled
//**********************************************************

`timescale 1ns/1ps

module channel_fir (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                spl_in,     // sample strobe
    input  logic                enable,     // filtering on
    input  video_pkg::pix_in_t  din,
    output video_pkg::pix_out_t dout
);

    import video_pkg::*;
    import filter_pkg::*;

    pix_in_t [0:num_taps-1]        hist;    // index 0 newest
    coeff_vec_t                    coeff_q; // rotates with hist
    logic [num_taps-1:0]           steps;   // one-hot tap pointer
    logic                          busy;
    logic [win+coeff_w-1:0]        prod;
    logic [acc_w-1:0]              acc;
    logic [acc_w-1:0]              acc_sh;
    pix_out_t                      clamped;
    pix_out_t                      fir_q;   // held filtered word
    pix_out_t                      widened;

    // counter runs out to zero after the last tap
    assign busy = |steps;

    // both registers rotate in step, so the head pair is always one tap
    assign prod = coeff_q[0] * hist[0];

    // scale back to colour range
    assign acc_sh = acc >> out_shift;

    // saturate when the sum overshoots five bits
    always_comb begin
        if (|acc_sh[acc_w-1:wout]) begin
            clamped = '1;                   // flat white stays white
        end else begin
            clamped = acc_sh[wout-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hist    <= '0;
            coeff_q <= '0;
            steps   <= '0;                  // idle
            acc     <= '0;
            fir_q   <= '0;
        end else if (spl_in) begin
            // accumulator holds the previous sample's sum here
            fir_q   <= clamped;
            hist    <= {din, hist[0:num_taps-2]}; // oldest drops out
            coeff_q <= coeff_tab;           // restart the table
            acc     <= '0;
            steps   <= num_taps'(1);        // first tap next cycle
        end else if (busy) begin
            acc     <= acc + acc_w'(prod);
            // full turn of num_taps rotations restores the order
            hist    <= {hist[1:num_taps-1], hist[0]};
            coeff_q <= {coeff_q[1:num_taps-1], coeff_q[0]};
            steps   <= steps << 1;          // last shift clears it
        end
    end

    // msbs copied into the new lsbs so 15 reaches 31
    assign widened = {din, din[win-1 -: wout-win]};

    // mux keeps bypass free of any extra cycle
    assign dout = enable ? fir_q : widened;

endmodule

//--- verilog/blank_mux.sv
//**********************************************************
// output register stage, colour blanking and sync register
//**********************************************************

`timescale 1ns/1ps

module blank_mux (
    input  logic                clk,
    input  logic                arst_n,
    input  video_pkg::pix_out_t chan_out [video_pkg::num_chan],
    video_sync_if.dst           sync,
    output video_pkg::pix_out_t r_out,
    output video_pkg::pix_out_t g_out,
    output video_pkg::pix_out_t b_out,
    output logic                hs_out,
    output logic                vs_out,
    output logic                lhb_out,
    output logic                lvb_out
);

    import video_pkg::*;

    logic     vis;                          // inside the active area
    pix_out_t colour_q [num_chan];

    // either blank line low means no picture
    assign vis = sync.lhb & sync.lvb;

    // colour and sync share one edge so they stay aligned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_chan; i++) begin
                colour_q[i] <= '0;
            end
            hs_out  <= 1'b0;
            vs_out  <= 1'b0;
            lhb_out <= 1'b0;
            lvb_out <= 1'b0;
        end else begin
            for (int i = 0; i < num_chan; i++) begin
                colour_q[i] <= vis ? chan_out[i] : '0;
            end
            hs_out  <= sync.hs;
            vs_out  <= sync.vs;
            lhb_out <= sync.lhb;
            lvb_out <= sync.lvb;
        end
    end

    assign r_out = colour_q[0];
    assign g_out = colour_q[1];
    assign b_out = colour_q[2];

endmodule

//--- verilog/video_bw_filter.sv
//**********************************************************
// video bandwidth filter top level
// front end, three fir channels and the output stage
//**********************************************************

`timescale 1ns/1ps

module video_bw_filter (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                spl_in,     // sample strobe
    input  logic                enable,     // filtering on
    input  video_pkg::pix_in_t  r_in,
    input  video_pkg::pix_in_t  g_in,
    input  video_pkg::pix_in_t  b_in,
    input  logic                hs_in,
    input  logic                vs_in,
    input  logic                lhb_in,
    input  logic                lvb_in,
    output video_pkg::pix_out_t r_out,
    output video_pkg::pix_out_t g_out,
    output video_pkg::pix_out_t b_out,
    output logic                hs_out,
    output logic                vs_out,
    output logic                lhb_out,
    output logic                lvb_out
);

    import video_pkg::*;

    pix_in_t  chan_in  [num_chan];          // r g b into the firs
    pix_out_t chan_out [num_chan];          // filtered or widened

    video_sync_if sync_bus ();              // selected sync

    sample_front u_front (
        .clk     (clk),
        .arst_n  (arst_n),
        .spl_in  (spl_in),
        .enable  (enable),
        .r_in    (r_in),
        .g_in    (g_in),
        .b_in    (b_in),
        .hs_in   (hs_in),
        .vs_in   (vs_in),
        .lhb_in  (lhb_in),
        .lvb_in  (lvb_in),
        .chan_in (chan_in),
        .sync    (sync_bus.src)
    );

    // one mac per colour, all fed the same strobe
    for (genvar i = 0; i < num_chan; i++) begin : gen_chan
        channel_fir u_fir (
            .clk    (clk),
            .arst_n (arst_n),
            .spl_in (spl_in),
            .enable (enable),
            .din    (chan_in[i]),
            .dout   (chan_out[i])
        );
    end

    blank_mux u_blank (
        .clk      (clk),
        .arst_n   (arst_n),
        .chan_out (chan_out),
        .sync     (sync_bus.dst),
        .r_out    (r_out),
        .g_out    (g_out),
        .b_out    (b_out),
        .hs_out   (hs_out),
        .vs_out   (vs_out),
        .lhb_out  (lhb_out),
        .lvb_out  (lvb_out)
    );

endmodule

//--- bench/clk_gen.sv
//**********************************************************
// testbench clock, 8 ns period, and asynchronous reset
//**********************************************************

`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    initial begin
        arst_n = 1'b0;                      // low from time zero
        repeat (4) @(posedge clk);
        @(negedge clk);                     // release away from the active edge
        arst_n = 1'b1;
    end

endmodule

//--- bench/video_bw_filter_sva.sv
//**********************************************************
// bound assertions for the video bandwidth filter
// strobe spacing, reset values and output blanking
//**********************************************************

`timescale 1ns/1ps

module video_bw_filter_sva (
    input logic                clk,
    input logic                arst_n,
    input logic                spl_in,
    input video_pkg::pix_out_t r_out,
    input video_pkg::pix_out_t g_out,
    input video_pkg::pix_out_t b_out,
    input logic                hs_out,
    input logic                vs_out,
    input logic                lhb_out,
    input logic                lvb_out
);

    import filter_pkg::*;

    int gap_cnt;                            // cycles since last strobe, saturates
    int fail_cnt = 0;                       // assertion failures so far

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gap_cnt <= min_strobe_gap;      // first strobe always allowed
        end else if (spl_in) begin
            gap_cnt <= 1;
        end else if (gap_cnt < min_strobe_gap) begin
            gap_cnt <= gap_cnt + 1;
        end
    end

    // mac needs all taps done before the next sample
    strobe_gap_a : assert property (@(posedge clk) disable iff (!arst_n)
        spl_in |-> gap_cnt >= min_strobe_gap)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("sample strobes closer than %0d cycles", min_strobe_gap);
        end

    reset_out_a : assert property (@(posedge clk)
        $rose(arst_n) |-> (r_out == '0 && g_out == '0 && b_out == '0 &&
                           !hs_out && !vs_out && !lhb_out && !lvb_out))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("outputs not cleared by reset");
        end

    // colour and sync leave the same register stage
    blank_a : assert property (@(posedge clk) disable iff (!arst_n)
        (!lhb_out || !lvb_out) |-> (r_out == '0 && g_out == '0 && b_out == '0))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("colour not zero while blanking is active");
        end

endmodule

//--- bench/tb_video_bw_filter.sv
//**********************************************************
// testbench for the video bandwidth filter
// stimulus table, reference model, checks and timeout
//**********************************************************

`timescale 1ns/1ps

module tb_video_bw_filter;

    import video_pkg::*;

    typedef struct packed {
        logic       en;                     // filtering on
        logic [3:0] sync;                   // hs vs lhb lvb
        logic       rnd_col;                // lcg colours
        logic       rnd_sync;               // lcg sync bits
        pix_in_t    r;
        pix_in_t    g;
        pix_in_t    b;
        logic [7:0] count;                  // strobes in this row
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        spl_in;
    logic        enable;
    pix_in_t     r_in;
    pix_in_t     g_in;
    pix_in_t     b_in;
    logic        hs_in;
    logic        vs_in;
    logic        lhb_in;
    logic        lvb_in;
    pix_out_t    r_out;
    pix_out_t    g_out;
    pix_out_t    b_out;
    logic        hs_out;
    logic        vs_out;
    logic        lhb_out;
    logic        lvb_out;

    row_t        rows [$];
    string       row_names [$];
    int          hist [3][5];               // model samples, index 0 newest
    logic [3:0]  sync_hist [4];             // model sync, index 0 newest
    logic [31:0] lcg_state = 32'hb2f9_1f9b;
    int          cycle_cnt = 0;
    int          cycle_limit = 100000;      // tightened once the table exists

    clk_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    video_bw_filter i_video_bw_filter (
        .clk     (clk),
        .arst_n  (arst_n),
        .spl_in  (spl_in),
        .enable  (enable),
        .r_in    (r_in),
        .g_in    (g_in),
        .b_in    (b_in),
        .hs_in   (hs_in),
        .vs_in   (vs_in),
        .lhb_in  (lhb_in),
        .lvb_in  (lvb_in),
        .r_out   (r_out),
        .g_out   (g_out),
        .b_out   (b_out),
        .hs_out  (hs_out),
        .vs_out  (vs_out),
        .lhb_out (lhb_out),
        .lvb_out (lvb_out)
    );

    bind video_bw_filter video_bw_filter_sva u_sva (
        .clk     (clk),
        .arst_n  (arst_n),
        .spl_in  (spl_in),
        .r_out   (r_out),
        .g_out   (g_out),
        .b_out   (b_out),
        .hs_out  (hs_out),
        .vs_out  (vs_out),
        .lhb_out (lhb_out),
        .lvb_out (lvb_out)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // symmetric low-pass weights, newest sample first
    function automatic int tap_weight(input int i);
        case (i)
            1, 3:    return 7;
            2:       return 20;             // centre
            default: return 0;
        endcase
    endfunction

    // msb repeated below the lsb, 15 -> 31
    function automatic int widen(input pix_in_t v);
        return (int'(v) << 1) | (int'(v) >> 3);
    endfunction

    // four-state compare so x or z on an output counts as a mismatch
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch at %0t", $time);
        end
    endtask

    task automatic add_row(input string name, input logic en, input logic [3:0] sync,
                           input logic rnd_col, input logic rnd_sync,
                           input int r, input int g, input int b, input int count);
        row_t row;
        row.en       = en;
        row.sync     = sync;
        row.rnd_col  = rnd_col;
        row.rnd_sync = rnd_sync;
        row.r        = pix_in_t'(r);
        row.g        = pix_in_t'(g);
        row.b        = pix_in_t'(b);
        row.count    = 8'(count);
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic build_table();
        // name             en  hs vs lhb lvb  rc rs  r   g   b   n
        add_row("bypass_widen",   0, 4'b1011, 0, 0, 15,  8,  3,  2);
        add_row("bypass_widen",   0, 4'b0111, 0, 0,  0,  7, 12,  1);
        add_row("bypass_blank",   0, 4'b1001, 0, 0, 15, 15, 15,  2);
        add_row("bypass_blank",   0, 4'b0110, 0, 0,  9,  4, 11,  2);
        add_row("filter_prime",   1, 4'b0011, 0, 0,  0,  0,  0,  6);
        add_row("filter_impulse", 1, 4'b0011, 0, 0, 15, 15, 15,  1);
        add_row("filter_impulse", 1, 4'b0011, 0, 0,  0,  0,  0,  6);
        add_row("filter_clamp",   1, 4'b0011, 0, 0, 15, 15, 15,  8);
        add_row("sync_delay",     1, 4'b1001, 0, 0,  9,  9,  9,  1);
        add_row("sync_delay",     1, 4'b0110, 0, 0,  9,  9,  9,  1);
        add_row("sync_delay",     1, 4'b0011, 0, 0,  9,  9,  9,  2);
        add_row("sync_delay",     1, 4'b1100, 0, 0,  9,  9,  9,  1);
        add_row("sync_delay",     1, 4'b0011, 0, 0,  9,  9,  9,  4);
        add_row("random_stream",  1, 4'b0011, 1, 1,  0,  0,  0, 40);
        add_row("random_bypass",  0, 4'b0011, 1, 1,  0,  0,  0, 12);
    endtask

    // one strobe, model update, then check just before the next strobe
    task automatic run_strobe(input string name, input logic en, input logic [3:0] s,
                              input pix_in_t r, input pix_in_t g, input pix_in_t b);
        int         col [3];
        int         acc;
        pix_in_t    cin [3];
        logic [3:0] sync_exp;
        cin[0] = r;
        cin[1] = g;
        cin[2] = b;
        enable = en;
        {hs_in, vs_in, lhb_in, lvb_in} = s;
        r_in   = r;
        g_in   = g;
        b_in   = b;
        spl_in = 1'b1;
        for (int ch = 0; ch < 3; ch++) begin
            acc = 0;
            for (int i = 0; i < 5; i++) begin
                acc += tap_weight(i) * hist[ch][i]; // previous history, F(m-1)
            end
            acc = acc >> 4;
            if (acc > 31) begin
                acc = 31;
            end
            for (int i = 4; i > 0; i--) begin
                hist[ch][i] = hist[ch][i-1];
            end
            hist[ch][0] = cin[ch];
            col[ch] = en ? acc : widen(cin[ch]);
        end
        for (int i = 3; i > 0; i--) begin
            sync_hist[i] = sync_hist[i-1];
        end
        sync_hist[0] = s;
        sync_exp = en ? sync_hist[3] : s;   // three strobes back when filtering
        if (!(sync_exp[1] && sync_exp[0])) begin
            col[0] = 0;
            col[1] = 0;
            col[2] = 0;
        end
        @(negedge clk);
        spl_in = 1'b0;
        repeat (7) @(negedge clk);
        check_value({name, " r_out"}, col[0], r_out);
        check_value({name, " g_out"}, col[1], g_out);
        check_value({name, " b_out"}, col[2], b_out);
        check_value({name, " hs_out"}, sync_exp[3], hs_out);
        check_value({name, " vs_out"}, sync_exp[2], vs_out);
        check_value({name, " lhb_out"}, sync_exp[1], lhb_out);
        check_value({name, " lvb_out"}, sync_exp[0], lvb_out);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout, test still running after %0d cycles", cycle_cnt);
            $display("*** TEST FAILED ***");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    // bound checker counts its failed assertions
    always @(i_video_bw_filter.u_sva.fail_cnt) begin
        if (i_video_bw_filter.u_sva.fail_cnt != 0) begin
            $display("a bound assertion failed, see the error above");
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure at %0t", $time);
        end
    end

    initial begin
        int         total;
        logic [3:0] s;
        pix_in_t    r;
        pix_in_t    g;
        pix_in_t    b;
        spl_in = 1'b0;
        enable = 1'b0;
        r_in   = '0;
        g_in   = '0;
        b_in   = '0;
        hs_in  = 1'b0;
        vs_in  = 1'b0;
        lhb_in = 1'b0;
        lvb_in = 1'b0;
        for (int ch = 0; ch < 3; ch++) begin
            for (int i = 0; i < 5; i++) begin
                hist[ch][i] = 0;
            end
        end
        for (int i = 0; i < 4; i++) begin
            sync_hist[i] = '0;
        end
        build_table();
        total = 0;
        for (int n = 0; n < rows.size(); n++) begin
            total += int'(rows[n].count);
        end
        cycle_limit = total * 8 + 16 + 64;  // 8 per strobe, reset, margin

        // no clock edge since release, outputs still hold reset values
        wait (arst_n === 1'b1);
        check_value("reset r_out", 0, r_out);
        check_value("reset g_out", 0, g_out);
        check_value("reset b_out", 0, b_out);
        check_value("reset hs_out", 0, hs_out);
        check_value("reset vs_out", 0, vs_out);
        check_value("reset lhb_out", 0, lhb_out);
        check_value("reset lvb_out", 0, lvb_out);

        for (int n = 0; n < rows.size(); n++) begin
            for (int k = 0; k < int'(rows[n].count); k++) begin
                s = rows[n].sync;
                r = rows[n].r;
                g = rows[n].g;
                b = rows[n].b;
                if (rows[n].rnd_col) begin
                    lcg_state = lcg_next(lcg_state);
                    r = lcg_state[31:28];   // upper bits mix best in an lcg
                    g = lcg_state[27:24];
                    b = lcg_state[23:20];
                end
                if (rows[n].rnd_sync) begin
                    lcg_state = lcg_next(lcg_state);
                    // blank lines low about a quarter of the time each
                    s = {lcg_state[31], lcg_state[30],
                         |lcg_state[29:28], |lcg_state[27:26]};
                end
                run_strobe(row_names[n], rows[n].en, s, r, g, b);
            end
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- list.f
verilog/video_pkg.sv
verilog/filter_pkg.sv
verilog/video_sync_if.sv
verilog/sample_front.sv
verilog/channel_fir.sv
verilog/blank_mux.sv
verilog/video_bw_filter.sv
bench/clk_gen.sv
bench/video_bw_filter_sva.sv
bench/tb_video_bw_filter.sv
